// File: Bender.yml
package:
  name: bp_branch_feedback

sources:
  - bp_fe_cmd_pkg.sv
  - bp_prof_pkg.sv
  - bp_fe_cmd_if.sv
  - bp_branch_resolver.sv
  - bp_fe_cmd_fifo.sv
  - bp_branch_profiler.sv
  - bp_branch_feedback_top.sv
  - target: simulation
    files:
      - tb_bp_branch_feedback.sv

// File: bp_branch_feedback_top.f
bp_fe_cmd_pkg.sv
bp_prof_pkg.sv
bp_fe_cmd_if.sv
bp_branch_resolver.sv
bp_fe_cmd_fifo.sv
bp_branch_profiler.sv
bp_branch_feedback_top.sv
tb_bp_branch_feedback.sv

// File: bp_branch_feedback_top.sv
`timescale 1ns/1ps

module bp_branch_feedback_top
  import bp_fe_cmd_pkg::*;
  import bp_prof_pkg::*;
  (input                                  clk_i
   , input                                reset_i
   , input                                freeze_i

   , input                                br_v_i
   , input [vaddr_width_lp-1:0]           br_pc_i
   , input                                br_pred_taken_i
   , input [vaddr_width_lp-1:0]           br_pred_tgt_i
   , input                                br_taken_i
   , input [vaddr_width_lp-1:0]           br_tgt_i
   , input bp_branch_metadata_s           br_meta_i
   , output logic                         br_ready_o

   , input                                fe_stall_i
   , output logic                         fe_cmd_v_o
   , output fe_cmd_opcode_e               fe_cmd_opcode_o
   , output logic [vaddr_width_lp-1:0]    fe_cmd_pc_o
   , output bp_branch_metadata_s          fe_cmd_meta_o

   , input                                commit_v_i
   , input prof_stat_e                    stat_sel_i
   , output logic [prof_cnt_width_lp-1:0] stat_o
   );

  bp_fe_cmd_if enq_if ();
  bp_fe_cmd_if deq_if ();

  // frontend takes the head whenever it is not stalled
  assign deq_if.yumi = ~fe_stall_i;

  bp_branch_resolver u_resolver
    (.clk_i            (clk_i)
     , .reset_i        (reset_i)
     , .br_v_i         (br_v_i)
     , .br_pc_i        (br_pc_i)
     , .br_pred_taken_i(br_pred_taken_i)
     , .br_pred_tgt_i  (br_pred_tgt_i)
     , .br_taken_i     (br_taken_i)
     , .br_tgt_i       (br_tgt_i)
     , .br_meta_i      (br_meta_i)
     , .br_ready_o     (br_ready_o)
     , .fe_cmd         (enq_if.producer)
     );

  bp_fe_cmd_fifo u_fifo
    (.clk_i            (clk_i)
     , .reset_i        (reset_i)
     , .fe_stall_i     (fe_stall_i)
     , .enq            (enq_if.consumer)
     , .fe_cmd_v_o     (fe_cmd_v_o)
     , .fe_cmd_opcode_o(fe_cmd_opcode_o)
     , .fe_cmd_pc_o    (fe_cmd_pc_o)
     , .fe_cmd_meta_o  (fe_cmd_meta_o)
     , .deq            (deq_if.producer)
     );

  bp_branch_profiler u_profiler
    (.clk_i       (clk_i)
     , .reset_i   (reset_i)
     , .freeze_i  (freeze_i)
     , .commit_v_i(commit_v_i)
     , .stat_sel_i(stat_sel_i)
     , .fe_cmd    (deq_if.monitor)
     , .stat_o    (stat_o)
     );

endmodule

// File: bp_branch_profiler.sv
`timescale 1ns/1ps

module bp_branch_profiler
  import bp_fe_cmd_pkg::*;
  import bp_prof_pkg::*;
  (input                                  clk_i
   , input                                reset_i
   , input                                freeze_i

   , input                                commit_v_i
   , input prof_stat_e                    stat_sel_i

   , bp_fe_cmd_if.monitor                 fe_cmd

   , output logic [prof_cnt_width_lp-1:0] stat_o
   );

  logic                         cmd_accept;
  logic                         attaboy_v;
  logic                         redirect_v;
  bp_branch_metadata_s          meta;
  logic [prof_num_stats_lp-1:0] stat_inc;
  logic [prof_cnt_width_lp-1:0] stat_cnt_r [prof_num_stats_lp];

  // the frontend took the head this cycle
  assign cmd_accept = fe_cmd.v & fe_cmd.yumi;
  assign attaboy_v  = cmd_accept & (fe_cmd.opcode == e_op_attaboy);
  assign redirect_v = cmd_accept & (fe_cmd.opcode == e_op_pc_redirection);
  assign meta       = fe_cmd.branch_metadata;

  always_comb
    begin
      stat_inc = '0;

      stat_inc[e_stat_instr]    = commit_v_i;
      stat_inc[e_stat_attaboy]  = attaboy_v;
      stat_inc[e_stat_redirect] = redirect_v;

      // kind counts include mispredicted ones
      stat_inc[e_stat_br]   = cmd_accept & meta.is_br;
      stat_inc[e_stat_jal]  = cmd_accept & meta.is_jal;
      stat_inc[e_stat_jalr] = cmd_accept & meta.is_jalr;

      // a hit only counts when the prediction held
      stat_inc[e_stat_btb_hit] = attaboy_v & meta.src_btb;
      stat_inc[e_stat_ras_hit] = attaboy_v & meta.src_ret;
      stat_inc[e_stat_bht_hit] = attaboy_v & meta.is_br;
    end

  always_ff @(posedge clk_i)
    if (reset_i)
      begin
        for (int i = 0; i < prof_num_stats_lp; i++)
          stat_cnt_r[i] <= '0;
      end
    else if (~freeze_i)
      begin
        for (int i = 0; i < prof_num_stats_lp; i++)
          stat_cnt_r[i] <= stat_cnt_r[i] + prof_cnt_width_lp'(stat_inc[i]);
      end

  // unused selects read zero
  always_comb
    begin
      stat_o = '0;
      case (stat_sel_i)
        e_stat_instr:    stat_o = stat_cnt_r[e_stat_instr];
        e_stat_attaboy:  stat_o = stat_cnt_r[e_stat_attaboy];
        e_stat_redirect: stat_o = stat_cnt_r[e_stat_redirect];
        e_stat_br:       stat_o = stat_cnt_r[e_stat_br];
        e_stat_jal:      stat_o = stat_cnt_r[e_stat_jal];
        e_stat_jalr:     stat_o = stat_cnt_r[e_stat_jalr];
        e_stat_btb_hit:  stat_o = stat_cnt_r[e_stat_btb_hit];
        e_stat_ras_hit:  stat_o = stat_cnt_r[e_stat_ras_hit];
        e_stat_bht_hit:  stat_o = stat_cnt_r[e_stat_bht_hit];
        default:         stat_o = '0;
      endcase
    end

endmodule

// File: bp_branch_resolver.sv
`timescale 1ns/1ps

module bp_branch_resolver
  import bp_fe_cmd_pkg::*;
  (input                               clk_i
   , input                             reset_i

   , input                             br_v_i
   , input [vaddr_width_lp-1:0]        br_pc_i
   , input                             br_pred_taken_i
   , input [vaddr_width_lp-1:0]        br_pred_tgt_i
   , input                             br_taken_i
   , input [vaddr_width_lp-1:0]        br_tgt_i
   , input bp_branch_metadata_s        br_meta_i
   , output logic                      br_ready_o

   , bp_fe_cmd_if.producer             fe_cmd
   );

  logic                      dir_miss;
  logic                      tgt_miss;
  logic                      mispredict;
  logic [vaddr_width_lp-1:0] next_pc;
  logic                      br_fire;
  logic                      cmd_v_r;
  bp_fe_cmd_s                cmd_r;

  // wrong direction, or right direction but wrong target
  assign dir_miss   = (br_pred_taken_i != br_taken_i);
  assign tgt_miss   = br_pred_taken_i & br_taken_i & (br_pred_tgt_i != br_tgt_i);
  assign mispredict = dir_miss | tgt_miss;

  // where the frontend should be fetching now
  assign next_pc = br_taken_i
                   ? br_tgt_i
                   : br_pc_i + vaddr_width_lp'(instr_bytes_lp);

  // free slot, or the slot empties this cycle
  assign br_ready_o = ~cmd_v_r | fe_cmd.yumi;
  assign br_fire    = br_v_i & br_ready_o;

  always_ff @(posedge clk_i)
    if (reset_i)
      cmd_v_r <= 1'b0;
    else if (br_ready_o)
      cmd_v_r <= br_v_i;

  // held unchanged while the queue is full
  always_ff @(posedge clk_i)
    if (br_fire)
      begin
        cmd_r.opcode          <= mispredict ? e_op_pc_redirection : e_op_attaboy;
        cmd_r.pc              <= next_pc;
        cmd_r.branch_metadata <= br_meta_i;
      end

  assign fe_cmd.v               = cmd_v_r;
  assign fe_cmd.opcode          = cmd_r.opcode;
  assign fe_cmd.pc              = cmd_r.pc;
  assign fe_cmd.branch_metadata = cmd_r.branch_metadata;

endmodule

// File: bp_fe_cmd_fifo.sv
`timescale 1ns/1ps

module bp_fe_cmd_fifo
  import bp_fe_cmd_pkg::*;
  (input                               clk_i
   , input                             reset_i
   , input                             fe_stall_i

   , bp_fe_cmd_if.consumer             enq

   , output logic                      fe_cmd_v_o
   , output fe_cmd_opcode_e            fe_cmd_opcode_o
   , output logic [vaddr_width_lp-1:0] fe_cmd_pc_o
   , output bp_branch_metadata_s       fe_cmd_meta_o

   , bp_fe_cmd_if.producer             deq
   );

  bp_fe_cmd_s                     mem_r [fe_cmd_fifo_els_lp];
  bp_fe_cmd_s                     head;
  logic [fe_cmd_ptr_width_lp-1:0] wr_ptr_r;
  logic [fe_cmd_ptr_width_lp-1:0] rd_ptr_r;
  logic [fe_cmd_cnt_width_lp-1:0] count_r;
  logic                           full;
  logic                           enq_fire;
  logic                           deq_fire;

  function automatic logic [fe_cmd_ptr_width_lp-1:0] ptr_next
    (input logic [fe_cmd_ptr_width_lp-1:0] ptr);
    if (ptr == fe_cmd_ptr_width_lp'(fe_cmd_fifo_els_lp - 1))
      return '0;
    else
      return ptr + 1'b1;
  endfunction

  assign full       = (count_r == fe_cmd_cnt_width_lp'(fe_cmd_fifo_els_lp));
  assign fe_cmd_v_o = (count_r != '0);
  assign deq_fire   = fe_cmd_v_o & ~fe_stall_i;

  // a full queue still takes a command when the head leaves
  assign enq.yumi = ~full | deq_fire;
  assign enq_fire = enq.v & enq.yumi;

  always_ff @(posedge clk_i)
    if (reset_i)
      begin
        wr_ptr_r <= '0;
        rd_ptr_r <= '0;
        count_r  <= '0;
      end
    else
      begin
        if (enq_fire)
          wr_ptr_r <= ptr_next(wr_ptr_r);
        if (deq_fire)
          rd_ptr_r <= ptr_next(rd_ptr_r);
        case ({enq_fire, deq_fire})
          2'b10:   count_r <= count_r + 1'b1;
          2'b01:   count_r <= count_r - 1'b1;
          default: count_r <= count_r;
        endcase
      end

  always_ff @(posedge clk_i)
    if (enq_fire)
      mem_r[wr_ptr_r] <= '{opcode:          enq.opcode,
                           pc:              enq.pc,
                           branch_metadata: enq.branch_metadata};

  assign head = mem_r[rd_ptr_r];

  assign fe_cmd_opcode_o = head.opcode;
  assign fe_cmd_pc_o     = head.pc;
  assign fe_cmd_meta_o   = head.branch_metadata;

  // head copy for the profiler
  assign deq.v               = fe_cmd_v_o;
  assign deq.opcode          = head.opcode;
  assign deq.pc              = head.pc;
  assign deq.branch_metadata = head.branch_metadata;

endmodule

// File: bp_fe_cmd_if.sv
`timescale 1ns/1ps

interface bp_fe_cmd_if
  import bp_fe_cmd_pkg::*;
  ();

  logic                      v;
  fe_cmd_opcode_e            opcode;
  logic [vaddr_width_lp-1:0] pc;
  bp_branch_metadata_s       branch_metadata;
  logic                      yumi;

  modport producer
    (output v
     , output opcode
     , output pc
     , output branch_metadata
     , input  yumi
     );

  modport consumer
    (input   v
     , input  opcode
     , input  pc
     , input  branch_metadata
     , output yumi
     );

  // observe only
  modport monitor
    (input  v
     , input opcode
     , input pc
     , input branch_metadata
     , input yumi
     );

endinterface

// File: bp_fe_cmd_pkg.sv
package bp_fe_cmd_pkg;

  // virtual address width of the core
  localparam int vaddr_width_lp = 39;

  // byte step to the fall-through instruction
  localparam int instr_bytes_lp = 4;

  // command queue sizing
  localparam int fe_cmd_fifo_els_lp  = 4;
  localparam int fe_cmd_ptr_width_lp = $clog2(fe_cmd_fifo_els_lp);
  localparam int fe_cmd_cnt_width_lp = fe_cmd_ptr_width_lp + 1;

  // subset of the frontend command set
  typedef enum logic [0:0]
  {
    e_op_attaboy        = 1'b0
    , e_op_pc_redirection = 1'b1
  } fe_cmd_opcode_e;

  // kind of instruction and where its prediction came from
  typedef struct packed
  {
    logic is_br;
    logic is_jal;
    logic is_jalr;
    logic src_btb;
    logic src_ret;
  } bp_branch_metadata_s;

  // one frontend command as it sits in a register or queue slot
  typedef struct packed
  {
    fe_cmd_opcode_e            opcode;
    logic [vaddr_width_lp-1:0] pc;
    bp_branch_metadata_s       branch_metadata;
  } bp_fe_cmd_s;

endpackage

// File: bp_prof_pkg.sv
package bp_prof_pkg;

  // counters wrap at this width
  localparam int prof_cnt_width_lp = 32;
  localparam int prof_num_stats_lp = 9;

  // statistic select for the read port
  typedef enum logic [3:0]
  {
    e_stat_instr      = 4'd0
    , e_stat_attaboy  = 4'd1
    , e_stat_redirect = 4'd2
    , e_stat_br       = 4'd3
    , e_stat_jal      = 4'd4
    , e_stat_jalr     = 4'd5
    , e_stat_btb_hit  = 4'd6
    , e_stat_ras_hit  = 4'd7
    , e_stat_bht_hit  = 4'd8
  } prof_stat_e;

endpackage

// File: tb_bp_branch_feedback.sv
`timescale 1ns/1ps

module tb_bp_branch_feedback
  import bp_fe_cmd_pkg::*;
  import bp_prof_pkg::*;
  ();

  localparam int num_rows_lp = 12;

  // one resolved branch, its stall pattern and the opcode it should produce
  typedef struct packed
  {
    logic [vaddr_width_lp-1:0] pc;
    logic                      pred_taken;
    logic [vaddr_width_lp-1:0] pred_tgt;
    logic                      taken;
    logic [vaddr_width_lp-1:0] tgt;
    bp_branch_metadata_s       meta;
    logic [3:0]                stall_pre;
    logic                      hold;
    logic                      freeze;
    fe_cmd_opcode_e            exp_op;
  } br_row_s;

  logic                         clk_i;
  logic                         reset_i;
  logic                         freeze_i;
  logic                         br_v_i;
  logic [vaddr_width_lp-1:0]    br_pc_i;
  logic                         br_pred_taken_i;
  logic [vaddr_width_lp-1:0]    br_pred_tgt_i;
  logic                         br_taken_i;
  logic [vaddr_width_lp-1:0]    br_tgt_i;
  bp_branch_metadata_s          br_meta_i;
  logic                         br_ready_o;
  logic                         fe_stall_i;
  logic                         fe_cmd_v_o;
  fe_cmd_opcode_e               fe_cmd_opcode_o;
  logic [vaddr_width_lp-1:0]    fe_cmd_pc_o;
  bp_branch_metadata_s          fe_cmd_meta_o;
  logic                         commit_v_i;
  prof_stat_e                   stat_sel_i;
  logic [prof_cnt_width_lp-1:0] stat_o;

  br_row_s                      tbl [num_rows_lp];
  bp_fe_cmd_s                   exp_q [$];
  logic [prof_cnt_width_lp-1:0] stat_model [prof_num_stats_lp];
  logic [prof_cnt_width_lp-1:0] stat_snap [prof_num_stats_lp];
  logic [31:0]                  lcg_state;
  logic                         fired;
  logic                         stall_hold;
  logic                         freeze_req;
  int                           accept_idx;

  bp_branch_feedback_top u_dut (.*);

  initial
    begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
    end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual)
      stop_with_error($sformatf("Mismatch in %s: expected %0h actual %0h",
                                name, expected, actual));
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // roughly one cycle in four
  function automatic logic rand_stall();
    lcg_state = lcg_next(lcg_state);
    return (lcg_state[29:28] == 2'b00);
  endfunction

  function automatic logic rand_commit();
    lcg_state = lcg_next(lcg_state);
    return lcg_state[30];
  endfunction

  // direction or target miss redirects
  function automatic bp_fe_cmd_s expected_cmd(input br_row_s r);
    bp_fe_cmd_s c;
    logic       miss;
    miss = (r.pred_taken != r.taken) || (r.pred_taken && r.taken && r.pred_tgt != r.tgt);
    c.opcode          = miss ? e_op_pc_redirection : e_op_attaboy;
    c.pc              = r.taken ? r.tgt : r.pc + vaddr_width_lp'(4);
    c.branch_metadata = r.meta;
    return c;
  endfunction

  task automatic count_accept(input bp_fe_cmd_s c);
    if (c.opcode == e_op_attaboy)
      begin
        stat_model[e_stat_attaboy] += 1;
        stat_model[e_stat_btb_hit] += c.branch_metadata.src_btb;
        stat_model[e_stat_ras_hit] += c.branch_metadata.src_ret;
        stat_model[e_stat_bht_hit] += c.branch_metadata.is_br;
      end
    else
      stat_model[e_stat_redirect] += 1;
    stat_model[e_stat_br]   += c.branch_metadata.is_br;
    stat_model[e_stat_jal]  += c.branch_metadata.is_jal;
    stat_model[e_stat_jalr] += c.branch_metadata.is_jalr;
  endtask

  // drive on the falling edge and look before the next rising edge
  task automatic step_cycle(input int row, input logic stall, input logic commit,
                            input prof_stat_e sel);
    bp_fe_cmd_s want;
    @(negedge clk_i);
    br_v_i = (row >= 0);
    if (row >= 0)
      begin
        br_pc_i         = tbl[row].pc;
        br_pred_taken_i = tbl[row].pred_taken;
        br_pred_tgt_i   = tbl[row].pred_tgt;
        br_taken_i      = tbl[row].taken;
        br_tgt_i        = tbl[row].tgt;
        br_meta_i       = tbl[row].meta;
      end
    fe_stall_i = stall;
    commit_v_i = commit;
    freeze_i   = freeze_req;
    stat_sel_i = sel;
    #1;
    fired = br_v_i & br_ready_o;
    if (fired)
      begin
        want = expected_cmd(tbl[row]);
        if (want.opcode != tbl[row].exp_op)
          stop_with_error($sformatf("table row %0d disagrees with the mispredict rule", row));
        exp_q.push_back(want);
      end
    if (fe_cmd_v_o && !fe_stall_i)
      begin
        if (exp_q.size() == 0)
          stop_with_error("the frontend accepted a command that no branch produced");
        want = exp_q.pop_front();
        check_value($sformatf("cmd %0d opcode", accept_idx), want.opcode, fe_cmd_opcode_o);
        check_value($sformatf("cmd %0d pc", accept_idx), want.pc, fe_cmd_pc_o);
        check_value($sformatf("cmd %0d meta", accept_idx), want.branch_metadata,
                    fe_cmd_meta_o);
        accept_idx++;
        if (!freeze_i)
          count_accept(want);
      end
    if (commit_v_i && !freeze_i)
      stat_model[e_stat_instr] += 1;
  endtask

  task automatic send_branch(input int row);
    for (int k = 0; k < tbl[row].stall_pre; k++)
      step_cycle(-1, 1'b1, rand_commit(), e_stat_instr);
    fired = 1'b0;
    while (!fired)
      step_cycle(row, stall_hold ? 1'b1 : rand_stall(), rand_commit(), e_stat_instr);
  endtask

  task automatic drain_queue();
    while (exp_q.size() != 0)
      step_cycle(-1, 1'b0, rand_commit(), e_stat_instr);
    step_cycle(-1, 1'b1, 1'b0, e_stat_instr);
    check_value("queue empty after drain", 0, fe_cmd_v_o);
  endtask

  task automatic check_stats(input string name, input logic use_snap);
    logic [prof_cnt_width_lp-1:0] want;
    for (int s = 0; s < prof_num_stats_lp; s++)
      begin
        step_cycle(-1, 1'b0, 1'b0, prof_stat_e'(s));
        want = use_snap ? stat_snap[s] : stat_model[s];
        check_value($sformatf("%s stat %0d", name, s), want, stat_o);
      end
  endtask

  initial
    begin
      repeat (num_rows_lp * 200) @(posedge clk_i);
      stop_with_error("timeout: the branch events did not all complete in time");
    end

  initial
    begin
      reset_i = 1'b1;
      freeze_i = 1'b0;
      br_v_i = 1'b0;
      br_pc_i = '0;
      br_pred_taken_i = 1'b0;
      br_pred_tgt_i = '0;
      br_taken_i = 1'b0;
      br_tgt_i = '0;
      br_meta_i = '0;
      fe_stall_i = 1'b0;
      commit_v_i = 1'b0;
      stat_sel_i = e_stat_instr;
      lcg_state = 32'h04fe7b21;
      stall_hold = 1'b0;
      freeze_req = 1'b0;
      accept_idx = 0;
      for (int s = 0; s < prof_num_stats_lp; s++)
        stat_model[s] = '0;

      // meta is {is_br, is_jal, is_jalr, src_btb, src_ret}
      tbl[0]  = '{39'h1000, 1'b1, 39'h1100, 1'b1, 39'h1100, 5'b10010, 4'd0, 1'b0, 1'b0,
                  e_op_attaboy};
      tbl[1]  = '{39'h1010, 1'b0, 39'h0, 1'b0, 39'h1200, 5'b10000, 4'd2, 1'b0, 1'b0,
                  e_op_attaboy};
      tbl[2]  = '{39'h1020, 1'b0, 39'h0, 1'b1, 39'h1300, 5'b10010, 4'd1, 1'b0, 1'b0,
                  e_op_pc_redirection};
      tbl[3]  = '{39'h1030, 1'b1, 39'h2000, 1'b1, 39'h2000, 5'b01010, 4'd0, 1'b0, 1'b0,
                  e_op_attaboy};
      tbl[4]  = '{39'h1040, 1'b1, 39'h3000, 1'b1, 39'h3040, 5'b00101, 4'd0, 1'b1, 1'b0,
                  e_op_pc_redirection};
      tbl[5]  = '{39'h1050, 1'b1, 39'h4000, 1'b1, 39'h4000, 5'b00101, 4'd0, 1'b1, 1'b0,
                  e_op_attaboy};
      tbl[6]  = '{39'h1060, 1'b1, 39'h1100, 1'b0, 39'h1100, 5'b10010, 4'd0, 1'b1, 1'b0,
                  e_op_pc_redirection};
      tbl[7]  = '{39'h1070, 1'b0, 39'h0, 1'b0, 39'h10, 5'b10000, 4'd0, 1'b1, 1'b0,
                  e_op_attaboy};
      tbl[8]  = '{39'h7ffffffffc, 1'b0, 39'h0, 1'b0, 39'h0, 5'b10000, 4'd0, 1'b1, 1'b0,
                  e_op_attaboy};
      tbl[9]  = '{39'h1090, 1'b1, 39'h5000, 1'b1, 39'h5000, 5'b01000, 4'd3, 1'b0, 1'b0,
                  e_op_attaboy};
      tbl[10] = '{39'h10a0, 1'b1, 39'h6000, 1'b1, 39'h6000, 5'b10010, 4'd0, 1'b0, 1'b1,
                  e_op_attaboy};
      tbl[11] = '{39'h10b0, 1'b0, 39'h0, 1'b1, 39'h7000, 5'b00101, 4'd1, 1'b0, 1'b1,
                  e_op_pc_redirection};

      repeat (3) @(posedge clk_i);
      @(negedge clk_i);
      reset_i = 1'b0;
      check_value("reset fe_cmd_v", 0, fe_cmd_v_o);
      check_value("reset br_ready", 1, br_ready_o);
      check_stats("reset", 1'b0);

      for (int i = 0; i < num_rows_lp; i++)
        begin
          if (tbl[i].hold && (i == 0 || !tbl[i-1].hold))
            drain_queue();
          if (tbl[i].freeze && (i == 0 || !tbl[i-1].freeze))
            begin
              drain_queue();
              check_stats("before freeze", 1'b0);
              for (int s = 0; s < prof_num_stats_lp; s++)
                stat_snap[s] = stat_model[s];
              freeze_req = 1'b1;
            end
          stall_hold = tbl[i].hold;
          send_branch(i);
          // resolver and queue now hold five commands
          if (tbl[i].hold && (i == num_rows_lp - 1 || !tbl[i+1].hold))
            begin
              step_cycle(-1, 1'b1, 1'b0, e_stat_instr);
              check_value("br_ready with queue full", 0, br_ready_o);
              check_value("fe_cmd_v while stalled", 1, fe_cmd_v_o);
              stall_hold = 1'b0;
            end
          if (tbl[i].freeze && (i == num_rows_lp - 1 || !tbl[i+1].freeze))
            begin
              drain_queue();
              check_stats("frozen", 1'b1);
              freeze_req = 1'b0;
            end
        end

      drain_queue();
      check_stats("final", 1'b0);
      $display("test passed");
      $finish;
    end

endmodule
